//--- list.f
logic/axi_wr_pkg.sv
logic/axi_skid_buffer.sv
logic/axi_wr_ingress_stage.sv
logic/axi_wr_egress_stage.sv
logic/axi_wr_noscale.sv
tb/tb_clock_gen.sv
tb/axi_wr_assert.sv
tb/tb_axi_wr_noscale.sv

//--- logic/axi_skid_buffer.sv
`timescale 1ns/10ps

module axi_skid_buffer #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             aclk,
    input  logic             rst_n,

    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,

    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count < CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Head entry comes straight from the storage flops
    assign out_data = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves occupancy unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : axi_skid_buffer

//--- logic/axi_wr_egress_stage.sv
`timescale 1ns/10ps

module axi_wr_egress_stage (
    input  logic               aclk,
    input  logic               rst_n,

    input  axi_wr_pkg::aw_pkt_t aw_mid,
    input  logic               aw_mid_valid,
    output logic               aw_mid_ready,

    input  axi_wr_pkg::w_pkt_t  w_mid,
    input  logic               w_mid_valid,
    output logic               w_mid_ready,

    output axi_wr_pkg::b_pkt_t  b_mid,
    output logic               b_mid_valid,
    input  logic               b_mid_ready,

    output axi_wr_pkg::aw_pkt_t m_aw,
    output logic               m_aw_valid,
    input  logic               m_aw_ready,

    output axi_wr_pkg::w_pkt_t  m_w,
    output logic               m_w_valid,
    input  logic               m_w_ready,

    input  axi_wr_pkg::b_pkt_t  m_b,
    input  logic               m_b_valid,
    output logic               m_b_ready
);

    import axi_wr_pkg::*;

    logic [AW_PKT_W-1:0] aw_flat;
    logic [W_PKT_W-1:0]  w_flat;
    logic [B_PKT_W-1:0]  b_flat;
    logic                aw_skid_valid;
    logic                below_limit;
    logic                aw_issue;
    logic                b_return;
    logic [OUTST_W-1:0]  outstanding;

    // Writes issued downstream still waiting for B
    assign below_limit = (outstanding != OUTST_W'(MAX_OUTSTANDING));
    assign m_aw_valid  = aw_skid_valid && below_limit;
    assign aw_issue    = m_aw_valid && m_aw_ready;
    assign b_return    = m_b_valid && m_b_ready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            case ({aw_issue, b_return})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    axi_skid_buffer #(.WIDTH(AW_PKT_W), .DEPTH(SKID_DEPTH_AW)) u_aw_skid (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (aw_mid),
        .in_valid  (aw_mid_valid),
        .in_ready  (aw_mid_ready),
        .out_data  (aw_flat),
        .out_valid (aw_skid_valid),
        .out_ready (m_aw_ready && below_limit)
    );
    assign m_aw = aw_pkt_t'(aw_flat);

    // Data is not held back by the limit
    axi_skid_buffer #(.WIDTH(W_PKT_W), .DEPTH(SKID_DEPTH_W)) u_w_skid (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (w_mid),
        .in_valid  (w_mid_valid),
        .in_ready  (w_mid_ready),
        .out_data  (w_flat),
        .out_valid (m_w_valid),
        .out_ready (m_w_ready)
    );
    assign m_w = w_pkt_t'(w_flat);

    axi_skid_buffer #(.WIDTH(B_PKT_W), .DEPTH(SKID_DEPTH_B)) u_b_skid (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (m_b),
        .in_valid  (m_b_valid),
        .in_ready  (m_b_ready),
        .out_data  (b_flat),
        .out_valid (b_mid_valid),
        .out_ready (b_mid_ready)
    );
    assign b_mid = b_pkt_t'(b_flat);

endmodule : axi_wr_egress_stage

//--- logic/axi_wr_ingress_stage.sv
`timescale 1ns/10ps

module axi_wr_ingress_stage (
    input  logic               aclk,
    input  logic               rst_n,

    input  axi_wr_pkg::aw_pkt_t s_aw,
    input  logic               s_aw_valid,
    output logic               s_aw_ready,

    input  axi_wr_pkg::w_pkt_t  s_w,
    input  logic               s_w_valid,
    output logic               s_w_ready,

    output axi_wr_pkg::b_pkt_t  s_b,
    output logic               s_b_valid,
    input  logic               s_b_ready,

    output axi_wr_pkg::aw_pkt_t aw_mid,
    output logic               aw_mid_valid,
    input  logic               aw_mid_ready,

    output axi_wr_pkg::w_pkt_t  w_mid,
    output logic               w_mid_valid,
    input  logic               w_mid_ready,

    input  axi_wr_pkg::b_pkt_t  b_mid,
    input  logic               b_mid_valid,
    output logic               b_mid_ready
);

    import axi_wr_pkg::*;

    logic [AW_PKT_W-1:0]  aw_flat;
    logic [W_PKT_W-1:0]   w_flat;
    logic [B_PKT_W-1:0]   b_flat;
    logic                 aw_skid_ready;
    logic                 w_skid_ready;
    logic                 aw_below_limit;
    logic                 aw_push;
    logic                 w_gate_open;
    logic                 w_last_push;
    logic [AW_PEND_W-1:0] aw_pending;

    // Bursts whose address is in but whose last beat is not
    assign aw_below_limit = (aw_pending != AW_PEND_W'(MAX_AW_PENDING));
    assign s_aw_ready     = aw_skid_ready && aw_below_limit;
    assign aw_push        = s_aw_valid && s_aw_ready;

    // W waits for its address, which may arrive in the same cycle
    assign w_gate_open = (aw_pending != '0) || aw_push;
    assign s_w_ready   = w_skid_ready && w_gate_open;
    assign w_last_push = s_w_valid && s_w_ready && s_w.last;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            aw_pending <= '0;
        end else begin
            case ({aw_push, w_last_push})
                2'b10:   aw_pending <= aw_pending + 1'b1;
                2'b01:   aw_pending <= aw_pending - 1'b1;
                default: aw_pending <= aw_pending;
            endcase
        end
    end

    axi_skid_buffer #(.WIDTH(AW_PKT_W), .DEPTH(SKID_DEPTH_AW)) u_aw_skid (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (s_aw),
        .in_valid  (s_aw_valid && aw_below_limit),
        .in_ready  (aw_skid_ready),
        .out_data  (aw_flat),
        .out_valid (aw_mid_valid),
        .out_ready (aw_mid_ready)
    );
    assign aw_mid = aw_pkt_t'(aw_flat);

    axi_skid_buffer #(.WIDTH(W_PKT_W), .DEPTH(SKID_DEPTH_W)) u_w_skid (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (s_w),
        .in_valid  (s_w_valid && w_gate_open),
        .in_ready  (w_skid_ready),
        .out_data  (w_flat),
        .out_valid (w_mid_valid),
        .out_ready (w_mid_ready)
    );
    assign w_mid = w_pkt_t'(w_flat);

    axi_skid_buffer #(.WIDTH(B_PKT_W), .DEPTH(SKID_DEPTH_B)) u_b_skid (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_data   (b_mid),
        .in_valid  (b_mid_valid),
        .in_ready  (b_mid_ready),
        .out_data  (b_flat),
        .out_valid (s_b_valid),
        .out_ready (s_b_ready)
    );
    assign s_b = b_pkt_t'(b_flat);

endmodule : axi_wr_ingress_stage

//--- logic/axi_wr_noscale.sv
`timescale 1ns/10ps

module axi_wr_noscale (
    input  logic               aclk,
    input  logic               rst_n,

    // Upstream write port
    input  axi_wr_pkg::aw_pkt_t s_aw,
    input  logic               s_aw_valid,
    output logic               s_aw_ready,
    input  axi_wr_pkg::w_pkt_t  s_w,
    input  logic               s_w_valid,
    output logic               s_w_ready,
    output axi_wr_pkg::b_pkt_t  s_b,
    output logic               s_b_valid,
    input  logic               s_b_ready,

    // Downstream write port
    output axi_wr_pkg::aw_pkt_t m_aw,
    output logic               m_aw_valid,
    input  logic               m_aw_ready,
    output axi_wr_pkg::w_pkt_t  m_w,
    output logic               m_w_valid,
    input  logic               m_w_ready,
    input  axi_wr_pkg::b_pkt_t  m_b,
    input  logic               m_b_valid,
    output logic               m_b_ready
);

    import axi_wr_pkg::*;

    aw_pkt_t aw_mid;
    logic    aw_mid_valid;
    logic    aw_mid_ready;
    w_pkt_t  w_mid;
    logic    w_mid_valid;
    logic    w_mid_ready;
    b_pkt_t  b_mid;
    logic    b_mid_valid;
    logic    b_mid_ready;

    axi_wr_ingress_stage u_ingress (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .s_aw         (s_aw),
        .s_aw_valid   (s_aw_valid),
        .s_aw_ready   (s_aw_ready),
        .s_w          (s_w),
        .s_w_valid    (s_w_valid),
        .s_w_ready    (s_w_ready),
        .s_b          (s_b),
        .s_b_valid    (s_b_valid),
        .s_b_ready    (s_b_ready),
        .aw_mid       (aw_mid),
        .aw_mid_valid (aw_mid_valid),
        .aw_mid_ready (aw_mid_ready),
        .w_mid        (w_mid),
        .w_mid_valid  (w_mid_valid),
        .w_mid_ready  (w_mid_ready),
        .b_mid        (b_mid),
        .b_mid_valid  (b_mid_valid),
        .b_mid_ready  (b_mid_ready)
    );

    axi_wr_egress_stage u_egress (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .aw_mid       (aw_mid),
        .aw_mid_valid (aw_mid_valid),
        .aw_mid_ready (aw_mid_ready),
        .w_mid        (w_mid),
        .w_mid_valid  (w_mid_valid),
        .w_mid_ready  (w_mid_ready),
        .b_mid        (b_mid),
        .b_mid_valid  (b_mid_valid),
        .b_mid_ready  (b_mid_ready),
        .m_aw         (m_aw),
        .m_aw_valid   (m_aw_valid),
        .m_aw_ready   (m_aw_ready),
        .m_w          (m_w),
        .m_w_valid    (m_w_valid),
        .m_w_ready    (m_w_ready),
        .m_b          (m_b),
        .m_b_valid    (m_b_valid),
        .m_b_ready    (m_b_ready)
    );

endmodule : axi_wr_noscale

//--- logic/axi_wr_pkg.sv
package axi_wr_pkg;

    // Bus widths, same on both sides
    localparam int ID_W   = 8;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int USER_W = 1;

    // Skid depths per channel
    localparam int SKID_DEPTH_AW = 2;
    localparam int SKID_DEPTH_W  = 4;
    localparam int SKID_DEPTH_B  = 2;

    // Flow limits and their counter widths
    localparam int MAX_AW_PENDING  = 15;
    localparam int AW_PEND_W       = $clog2(MAX_AW_PENDING + 1);
    localparam int MAX_OUTSTANDING = 8;
    localparam int OUTST_W         = $clog2(MAX_OUTSTANDING + 1);

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic              lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
        logic [3:0]        qos;
        logic [3:0]        region;
        logic [USER_W-1:0] user;
    } aw_pkt_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
        logic [USER_W-1:0] user;
    } w_pkt_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [1:0]        resp;
        logic [USER_W-1:0] user;
    } b_pkt_t;

    // Flat widths for the skid buffers
    localparam int AW_PKT_W = $bits(aw_pkt_t);
    localparam int W_PKT_W  = $bits(w_pkt_t);
    localparam int B_PKT_W  = $bits(b_pkt_t);

endpackage : axi_wr_pkg

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI write path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_axi_wr_noscale -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
exit 0

//--- tb/axi_wr_assert.sv
`timescale 1ns/10ps

module axi_wr_assert (
    input logic                aclk,
    input logic                rst_n,
    input axi_wr_pkg::aw_pkt_t m_aw,
    input logic                m_aw_valid,
    input logic                m_aw_ready,
    input axi_wr_pkg::w_pkt_t  m_w,
    input logic                m_w_valid,
    input logic                m_w_ready,
    input axi_wr_pkg::b_pkt_t  s_b,
    input logic                s_b_valid,
    input logic                s_b_ready
);

    // Outputs idle in the first cycle out of reset
    reset_idle: assert property (@(posedge aclk)
        $rose(rst_n) |-> !m_aw_valid && !m_w_valid && !s_b_valid)
        else $error("valid high in the first cycle after reset");

    aw_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw))
        else $error("m_aw dropped or changed before it was accepted");

    w_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        m_w_valid && !m_w_ready |=> m_w_valid && $stable(m_w))
        else $error("m_w dropped or changed before it was accepted");

    b_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
        else $error("s_b dropped or changed before it was accepted");

endmodule : axi_wr_assert

bind axi_wr_noscale axi_wr_assert u_assert (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_w        (m_w),
    .m_w_valid  (m_w_valid),
    .m_w_ready  (m_w_ready),
    .s_b        (s_b),
    .s_b_valid  (s_b_valid),
    .s_b_ready  (s_b_ready)
);

//--- tb/axi_wr_testdata.txt
// test  id  addr      len  data_seed  bresp
// one write per line, beat k carries data_seed + k
01 11 00001000 00 a0000000 0
01 12 00001040 03 a1000010 1
01 13 00002000 01 a2000020 0
02 21 00003000 02 b0000000 0
03 31 00004000 00 c0000000 0
03 32 00004010 01 c1000000 1
03 33 00004020 00 c2000000 0
03 34 00004030 01 c3000000 2
03 35 00004040 00 c4000000 0
03 36 00004050 01 c5000000 3
03 37 00004060 00 c6000000 0
03 38 00004070 01 c7000000 1
03 39 00004080 00 c8000000 0
03 3a 00004090 01 c9000000 2
04 41 00005000 03 d0000000 0
04 42 00005100 01 d1000000 2
04 43 00005200 00 d2000000 1
04 44 00005300 02 d3000000 0
04 45 00005400 03 d4000000 3
04 46 00005500 01 d5000000 0

//--- tb/tb_axi_wr_noscale.sv
`timescale 1ns/10ps

module tb_axi_wr_noscale;

    import axi_wr_pkg::*;

    localparam int NUM_TXN = 20;
    localparam int COLS    = 6;
    localparam int TIMEOUT = 2000;

    logic    aclk;
    logic    rst_n;
    aw_pkt_t s_aw;
    logic    s_aw_valid;
    logic    s_aw_ready;
    w_pkt_t  s_w;
    logic    s_w_valid;
    logic    s_w_ready;
    b_pkt_t  s_b;
    logic    s_b_valid;
    logic    s_b_ready;
    aw_pkt_t m_aw;
    logic    m_aw_valid;
    logic    m_aw_ready;
    w_pkt_t  m_w;
    logic    m_w_valid;
    logic    m_w_ready;
    b_pkt_t  m_b;
    logic    m_b_valid;
    logic    m_b_ready;

    logic [31:0] tdata [NUM_TXN*COLS];
    logic [31:0] lfsr = 32'h661c;
    aw_pkt_t     aw_exp_q [$];
    w_pkt_t      w_exp_q [$];
    b_pkt_t      b_exp_q [$];
    b_pkt_t      b_pend_q [$];
    logic [1:0]  resp_q [$];
    int          outstanding = 0;
    int          checks = 0;
    int          errors = 0;
    logic        bp_mode = 1'b0;
    logic        hold_b = 1'b0;
    string       test_names [4] = '{"basic pass-through", "W held behind AW",
                                    "outstanding limit", "random back-pressure"};

    tb_clock_gen u_clk (.aclk(aclk), .rst_n(rst_n));

    axi_wr_noscale dut_i (.*);

    // Taps 32, 22, 2, 1
    function automatic logic next_rand_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic aw_pkt_t make_aw(input int i);
        aw_pkt_t p;
        p       = '0;
        p.id    = tdata[i*COLS+1][ID_W-1:0];
        p.addr  = tdata[i*COLS+2];
        p.len   = tdata[i*COLS+3][7:0];
        p.size  = 3'd2;
        p.burst = 2'b01;
        p.cache = 4'b0011;
        p.prot  = p.id[2:0];
        p.qos   = 4'(i);
        p.user  = p.id[0];
        return p;
    endfunction

    function automatic w_pkt_t make_beat(input int i, input int k);
        w_pkt_t b;
        b.data = tdata[i*COLS+4] + 32'(k);
        b.strb = '1;
        b.last = (k == int'(tdata[i*COLS+3][7:0]));
        b.user = '0;
        return b;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_extra(input string channel);
        errors++;
        $display("Unexpected transfer on %s with nothing left to compare at %0t", channel, $time);
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s did not arrive in time", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic send_aw(input int i);
        aw_pkt_t p;
        b_pkt_t  eb;
        int      n;
        p       = make_aw(i);
        eb.id   = p.id;
        eb.resp = tdata[i*COLS+5][1:0];
        eb.user = '0;
        if (bp_mode && next_rand_bit()) begin
            @(posedge aclk);
            #1;
        end
        aw_exp_q.push_back(p);
        resp_q.push_back(eb.resp);
        b_exp_q.push_back(eb);
        s_aw       = p;
        s_aw_valid = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
            if (n > TIMEOUT) abort_run("s_aw_ready");
        end while (!s_aw_ready);
        @(posedge aclk);
        #1;
        s_aw_valid = 1'b0;
    endtask

    task automatic send_w(input int i);
        w_pkt_t b;
        int     n;
        int     k;
        for (k = 0; k <= int'(tdata[i*COLS+3][7:0]); k++) begin
            if (bp_mode && next_rand_bit()) begin
                @(posedge aclk);
                #1;
            end
            b = make_beat(i, k);
            w_exp_q.push_back(b);
            s_w       = b;
            s_w_valid = 1'b1;
            n = 0;
            do begin
                @(negedge aclk);
                n++;
                if (n > TIMEOUT) abort_run("s_w_ready");
            end while (!s_w_ready);
            @(posedge aclk);
            #1;
            s_w_valid = 1'b0;
        end
    endtask

    // First beat offered with no burst address pending
    task automatic offer_w_early(input int i);
        s_w       = make_beat(i, 0);
        s_w_valid = 1'b1;
        repeat (4) begin
            @(negedge aclk);
            check_value("s_w_ready before AW", 128'(s_w_ready), 128'd0);
        end
        @(posedge aclk);
        #1;
    endtask

    task automatic run_test(input int t);
        int err_mark;
        int n;
        int i;
        err_mark = errors;
        bp_mode  = (t == 4);
        hold_b   = (t == 3);
        for (i = 0; i < NUM_TXN; i++) begin
            if (tdata[i*COLS] == 32'(t)) begin
                if (t == 2) offer_w_early(i);
                fork
                    send_aw(i);
                    send_w(i);
                join
            end
        end
        if (t == 3) begin
            n = 0;
            while (outstanding != MAX_OUTSTANDING) begin
                @(negedge aclk);
                n++;
                if (n > TIMEOUT) abort_run("last write allowed on m_aw");
            end
            repeat (2) @(negedge aclk);
            check_value("m_aw_valid at limit", 128'(m_aw_valid), 128'd0);
            check_value("writes awaiting B", 128'(outstanding), 128'(MAX_OUTSTANDING));
            @(posedge aclk);
            #1;
            hold_b = 1'b0;
        end
        n = 0;
        while (aw_exp_q.size() + w_exp_q.size() + b_exp_q.size() != 0) begin
            @(posedge aclk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("every write and response of the test");
        end
        bp_mode = 1'b0;
        $display("test %0d %s: %0d errors", t, test_names[t-1], errors - err_mark);
    endtask

    // Downstream slave model plus monitors on m_aw, m_w and s_b
    initial begin : downstream
        b_pkt_t rb;
        logic   b_taken;
        b_taken = 1'b0;
        forever begin
            @(negedge aclk);
            if (rst_n) begin
                if (m_aw_valid && m_aw_ready) begin
                    if (aw_exp_q.size() == 0) begin
                        report_extra("m_aw");
                    end else begin
                        check_value("m_aw", 128'(m_aw), 128'(aw_exp_q.pop_front()));
                        rb.id   = m_aw.id;
                        rb.resp = resp_q.pop_front();
                        rb.user = '0;
                        b_pend_q.push_back(rb);
                    end
                    outstanding++;
                    check_value("writes awaiting B within limit",
                                128'(outstanding <= MAX_OUTSTANDING), 128'd1);
                end
                if (m_w_valid && m_w_ready) begin
                    if (w_exp_q.size() == 0) report_extra("m_w");
                    else check_value("m_w", 128'(m_w), 128'(w_exp_q.pop_front()));
                end
                if (m_b_valid && m_b_ready) begin
                    outstanding--;
                    b_taken = 1'b1;
                end
                if (s_b_valid && s_b_ready) begin
                    if (b_exp_q.size() == 0) report_extra("s_b");
                    else check_value("s_b", 128'(s_b), 128'(b_exp_q.pop_front()));
                end
            end
            @(posedge aclk);
            #1;
            if (bp_mode) begin
                m_aw_ready = next_rand_bit();
                m_w_ready  = next_rand_bit();
                s_b_ready  = next_rand_bit();
            end else begin
                m_aw_ready = 1'b1;
                m_w_ready  = 1'b1;
                s_b_ready  = 1'b1;
            end
            if (b_taken) m_b_valid = 1'b0;
            b_taken = 1'b0;
            if (!m_b_valid && !hold_b && b_pend_q.size() > 0) begin
                m_b       = b_pend_q.pop_front();
                m_b_valid = 1'b1;
            end
        end
    end

    initial begin : main
        int n;
        int t;
        s_aw       = '0;
        s_aw_valid = 1'b0;
        s_w        = '0;
        s_w_valid  = 1'b0;
        s_b_ready  = 1'b0;
        m_aw_ready = 1'b0;
        m_w_ready  = 1'b0;
        m_b        = '0;
        m_b_valid  = 1'b0;
        $readmemh("tb/axi_wr_testdata.txt", tdata);
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge aclk);
            n++;
            if (n > TIMEOUT) abort_run("reset release");
        end
        @(posedge aclk);
        #1;
        for (t = 1; t <= 4; t++) run_test(t);
        $display("tests run: 4, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_axi_wr_noscale

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic aclk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Reset held low over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;
    end

endmodule : tb_clock_gen
